//--- src.f
+incdir+bench
design/sys_pkg.sv
design/req_queue.sv
design/bus_fsm.sv
design/data_ram.sv
design/gpio_regs.sv
design/mtimer.sv
design/periph_top.sv
bench/tb_periph_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_periph_top -o tb_sim -f src.f

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q -F "*** TEST PASSED ***" sim.log; then
  exit 0
fi
exit 1

//--- bench/tb_tests.svh
// Test table rows, check kinds, LCG and table builder.
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// Response checks.
localparam int ChkErr    = 0;
localparam int ChkData   = 1;
localparam int ChkMore   = 2;
localparam int ChkGpo    = 3;
localparam int ChkIrqLow = 4;

// Host actions after the response.
localparam int PostNone    = 0;
localparam int PostIrqHigh = 1;
localparam int PostGap     = 2;

localparam int NumTests = 21;

// For ChkGpo rows the rdata column holds the expected gp_o.
typedef struct {
  string                    name;
  bus_op_e                  op;
  logic [BusAddrWidth-1:0]  addr;
  logic [BusDataWidth-1:0]  wdata;
  logic [BusByteEnable-1:0] be;
  logic [GpiWidth-1:0]      gpi;
  logic [BusDataWidth-1:0]  rdata;
  logic                     err;
  int                       chk;
  int                       post;
} test_row_t;

test_row_t   tests [NumTests];
logic [31:0] lcg_state;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic void set_row(
  input int                       idx,
  input string                    name,
  input bus_op_e                  op,
  input logic [BusAddrWidth-1:0]  addr,
  input logic [BusDataWidth-1:0]  wdata,
  input logic [BusByteEnable-1:0] be,
  input logic [GpiWidth-1:0]      gpi,
  input logic [BusDataWidth-1:0]  rdata,
  input logic                     err,
  input int                       chk,
  input int                       post
);
  tests[idx].name  = name;
  tests[idx].op    = op;
  tests[idx].addr  = addr;
  tests[idx].wdata = wdata;
  tests[idx].be    = be;
  tests[idx].gpi   = gpi;
  tests[idx].rdata = rdata;
  tests[idx].err   = err;
  tests[idx].chk   = chk;
  tests[idx].post  = post;
endfunction

function automatic void build_table();
  logic [31:0]         w_full;
  logic [31:0]         w_part;
  logic [31:0]         w_last;
  logic [31:0]         w_gpo;
  logic [31:0]         w_gpi;
  logic [31:0]         mask;
  logic [31:0]         gpo_exp;
  logic [GpiWidth-1:0] gpi;
  lcg_state = 32'hf37b;
  w_full    = lcg_next();
  w_part    = lcg_next();
  w_last    = lcg_next();
  w_gpo     = lcg_next();
  w_gpi     = lcg_next();
  gpi       = w_gpi[GpiWidth-1:0];
  // Lanes 0 and 2 come from the second write.
  mask      = 32'h00ff_00ff;
  gpo_exp   = w_gpo & ((32'd1 << GpoWidth) - 32'd1);

  ////////////////////
  // RAM lanes and back-to-back traffic.
  set_row(0, "ram full write", OpWrite, RamBase + 32'h40, w_full, 4'hf, '0, '0, 1'b0,
          ChkErr, PostNone);
  set_row(1, "ram partial write", OpWrite, RamBase + 32'h40, w_part, 4'h5, '0, '0, 1'b0,
          ChkErr, PostNone);
  set_row(2, "ram merge read", OpRead, RamBase + 32'h40, '0, 4'hf, '0,
          (w_full & ~mask) | (w_part & mask), 1'b0, ChkData, PostNone);
  set_row(3, "ram last write", OpWrite, RamBase + 32'h3fc, w_last, 4'hf, '0, '0, 1'b0,
          ChkErr, PostNone);
  set_row(4, "ram last read", OpRead, RamBase + 32'h3fc, '0, 4'hf, '0, w_last, 1'b0,
          ChkData, PostNone);

  ////////////////////
  // GPIO.
  set_row(5, "gpo write", OpWrite, GpioBase + 32'(GpoOffset), w_gpo, 4'hf, '0, gpo_exp, 1'b0,
          ChkGpo, PostNone);
  set_row(6, "gpo readback", OpRead, GpioBase + 32'(GpoOffset), '0, 4'hf, '0, gpo_exp, 1'b0,
          ChkData, PostNone);
  set_row(7, "gpi read", OpRead, GpioBase + 32'(GpiOffset), '0, 4'hf, gpi,
          BusDataWidth'(gpi), 1'b0, ChkData, PostNone);
  set_row(8, "gpi write ignored", OpWrite, GpioBase + 32'(GpiOffset), ~w_gpi, 4'hf, gpi, '0,
          1'b0, ChkErr, PostNone);
  set_row(9, "gpi read again", OpRead, GpioBase + 32'(GpiOffset), '0, 4'hf, gpi,
          BusDataWidth'(gpi), 1'b0, ChkData, PostNone);

  ////////////////////
  // Decode errors.
  set_row(10, "unmapped read", OpRead, 32'h4000_0000, '0, 4'hf, gpi, '0, 1'b1,
          ChkData, PostNone);
  set_row(11, "unmapped write", OpWrite, 32'h4000_0000, w_full, 4'hf, gpi, '0, 1'b1,
          ChkData, PostNone);
  set_row(12, "beyond ram read", OpRead, RamBase + 32'(RamWords * 4), '0, 4'hf, gpi, '0,
          1'b1, ChkData, PostNone);
  set_row(13, "timer bad offset", OpRead, TimerBase + 32'h0c, '0, 4'hf, gpi, '0, 1'b1,
          ChkErr, PostNone);

  ////////////////////
  // Timer.
  set_row(14, "mtimecmp zero", OpWrite, TimerBase + 32'(MtimecmpOffset), '0, 4'hf, gpi, '0,
          1'b0, ChkErr, PostNone);
  set_row(15, "timer enable", OpWrite, TimerBase + 32'(TimerCtrlOffset), 32'h1, 4'hf, gpi,
          '0, 1'b0, ChkErr, PostIrqHigh);
  set_row(16, "mtimecmp max", OpWrite, TimerBase + 32'(MtimecmpOffset), '1, 4'hf, gpi, '0,
          1'b0, ChkIrqLow, PostNone);
  set_row(17, "mtime first read", OpRead, TimerBase + 32'(MtimeOffset), '0, 4'hf, gpi, '0,
          1'b0, ChkErr, PostGap);
  set_row(18, "mtime second read", OpRead, TimerBase + 32'(MtimeOffset), '0, 4'hf, gpi, '0,
          1'b0, ChkMore, PostNone);
  // Raise the interrupt again so that the disable has something to clear.
  set_row(19, "mtimecmp zero again", OpWrite, TimerBase + 32'(MtimecmpOffset), '0, 4'hf, gpi,
          '0, 1'b0, ChkErr, PostIrqHigh);
  set_row(20, "timer disable", OpWrite, TimerBase + 32'(TimerCtrlOffset), '0, 4'hf, gpi,
          '0, 1'b0, ChkIrqLow, PostNone);
endfunction

`endif

//--- bench/tb_periph_top.sv
// Testbench for the peripheral subsystem: clock, reset, driver, monitor and checks.
`timescale 1ns/1ps

module tb_periph_top import sys_pkg::*; ();

  localparam int ReqDepth  = 2;
  localparam int RamWords  = 256;
  localparam int GpiWidth  = 13;
  localparam int GpoWidth  = 24;
  localparam int TickDiv   = 4;
  localparam int WaitLimit = 200;

  logic                     clk_sys;
  logic                     rst_n;
  logic                     req_valid;
  bus_op_e                  req_op;
  logic [BusAddrWidth-1:0]  req_addr;
  logic [BusDataWidth-1:0]  req_wdata;
  logic [BusByteEnable-1:0] req_be;
  logic                     credit;
  logic                     rsp_valid;
  logic [BusDataWidth-1:0]  rsp_rdata;
  logic                     rsp_err;
  logic [GpiWidth-1:0]      gp_in;
  logic [GpoWidth-1:0]      gp_out;
  logic                     irq;

  // Driver side.
  int issued;
  int exp_order[$];
  int final_errors;
  bit timed_out;
  // Monitor side.
  int credit_pulses;
  int rsp_count;
  int checks_failed;
  int tests_failed;
  logic [BusDataWidth-1:0] prev_rdata;
  event sampled;

  `include "tb_tests.svh"

  periph_top #(
    .ReqDepth(ReqDepth),
    .RamWords(RamWords),
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth),
    .TickDiv (TickDiv)
  ) DUT (
    .clk_sys_i  (clk_sys),
    .rst_n_i    (rst_n),
    .req_valid_i(req_valid),
    .req_op_i   (req_op),
    .req_addr_i (req_addr),
    .req_wdata_i(req_wdata),
    .req_be_i   (req_be),
    .credit_o   (credit),
    .rsp_valid_o(rsp_valid),
    .rsp_rdata_o(rsp_rdata),
    .rsp_err_o  (rsp_err),
    .gp_i       (gp_in),
    .gp_o       (gp_out),
    .irq_o      (irq)
  );

  initial begin
    clk_sys = 1'b0;
    forever #10 clk_sys = ~clk_sys;
  end

  task automatic report_timeout(input string why);
    $display("error at %0t: %s", $time, why);
    timed_out = 1'b1;
    final_errors++;
  endtask

  ////////////////////
  // Driver helpers.
  ////////////////////

  task automatic idle_cycle();
    @(posedge clk_sys);
    req_valid <= 1'b0;
    @(sampled);
  endtask

  task automatic wait_credit();
    int cycles;
    cycles = 0;
    while (!timed_out && ReqDepth - issued + credit_pulses <= 0) begin
      if (cycles == WaitLimit) begin
        report_timeout("no credit came back to the host");
      end else begin
        idle_cycle();
        cycles++;
      end
    end
  endtask

  task automatic wait_responses(input int count);
    int cycles;
    cycles = 0;
    while (!timed_out && rsp_count < count) begin
      if (cycles == WaitLimit) begin
        report_timeout("response did not arrive");
      end else begin
        idle_cycle();
        cycles++;
      end
    end
  endtask

  task automatic wait_gpi_sync(input logic [GpiWidth-1:0] value);
    int cycles;
    cycles = 0;
    @(sampled);
    while (!timed_out && DUT.u_gpio_regs.gpi_sync !== value) begin
      if (cycles == WaitLimit) begin
        report_timeout("GPI synchronizer did not follow gp_i");
      end else begin
        idle_cycle();
        cycles++;
      end
    end
  endtask

  task automatic wait_irq_high();
    int cycles;
    cycles = 0;
    while (!timed_out && irq !== 1'b1) begin
      if (cycles == WaitLimit) begin
        report_timeout("irq_o did not rise after the timer was enabled");
      end else begin
        idle_cycle();
        cycles++;
      end
    end
  endtask

  task automatic issue_row(input int idx);
    @(posedge clk_sys);
    req_valid <= 1'b1;
    req_op    <= tests[idx].op;
    req_addr  <= tests[idx].addr;
    req_wdata <= tests[idx].wdata;
    req_be    <= tests[idx].be;
    issued++;
    exp_order.push_back(idx);
    @(sampled);
  endtask

  ////////////////////
  // Response monitor.
  ////////////////////

  task automatic check_response();
    int   idx;
    logic row_ok;
    if (rsp_count >= exp_order.size()) begin
      $display("error at %0t: response with no request outstanding", $time);
      checks_failed++;
    end else begin
      idx    = exp_order[rsp_count];
      row_ok = 1'b1;
      if (rsp_err !== tests[idx].err) begin
        $display("mismatch at %0t: rsp_err_o got %0b expected %0b", $time, rsp_err,
                 tests[idx].err);
        row_ok = 1'b0;
      end
      if (tests[idx].chk == ChkData && rsp_rdata !== tests[idx].rdata) begin
        $display("mismatch at %0t: rsp_rdata_o got %h expected %h", $time, rsp_rdata,
                 tests[idx].rdata);
        row_ok = 1'b0;
      end
      if (tests[idx].chk == ChkMore && !(rsp_rdata > prev_rdata)) begin
        $display("mismatch at %0t: rsp_rdata_o got %h expected above %h", $time, rsp_rdata,
                 prev_rdata);
        row_ok = 1'b0;
      end
      if (tests[idx].chk == ChkGpo && gp_out !== tests[idx].rdata[GpoWidth-1:0]) begin
        $display("mismatch at %0t: gp_o got %h expected %h", $time, gp_out,
                 tests[idx].rdata[GpoWidth-1:0]);
        row_ok = 1'b0;
      end
      if (tests[idx].chk == ChkIrqLow && irq !== 1'b0) begin
        $display("mismatch at %0t: irq_o got %b expected 0", $time, irq);
        row_ok = 1'b0;
      end
      if (row_ok) begin
        $display("test %0d %s: ok", idx, tests[idx].name);
      end else begin
        $display("test %0d %s: failed", idx, tests[idx].name);
        tests_failed++;
        checks_failed++;
      end
      prev_rdata = rsp_rdata;
      rsp_count++;
    end
  endtask

  always @(negedge clk_sys) begin
    if (rst_n && credit) credit_pulses++;
    if (rst_n && rsp_valid) check_response();
    // The driver resumes once this cycle is counted.
    -> sampled;
  end

  ////////////////////
  // Main sequence.
  ////////////////////

  initial begin
    rst_n         = 1'b0;
    req_valid     = 1'b0;
    req_op        = OpRead;
    req_addr      = '0;
    req_wdata     = '0;
    req_be        = '0;
    gp_in         = '0;
    issued        = 0;
    final_errors  = 0;
    timed_out     = 1'b0;
    credit_pulses = 0;
    rsp_count     = 0;
    checks_failed = 0;
    tests_failed  = 0;
    prev_rdata    = '0;
    build_table();
    repeat (5) @(posedge clk_sys);
    rst_n <= 1'b1;
    for (int i = 0; i < NumTests && !timed_out; i++) begin
      if (gp_in !== tests[i].gpi) begin
        @(posedge clk_sys);
        req_valid <= 1'b0;
        gp_in     <= tests[i].gpi;
        wait_gpi_sync(tests[i].gpi);
      end
      wait_credit();
      if (!timed_out) begin
        issue_row(i);
      end
      if (tests[i].post == PostIrqHigh) begin
        wait_responses(i + 1);
        wait_irq_high();
      end
      // Space the two mtime reads by more than one tick.
      if (tests[i].post == PostGap) begin
        wait_responses(i + 1);
        repeat (TickDiv + 2) idle_cycle();
      end
    end
    @(posedge clk_sys);
    req_valid <= 1'b0;
    wait_responses(NumTests);
    if (credit_pulses != issued) begin
      $display("mismatch at %0t: credit_o pulses got %0d expected %0d", $time, credit_pulses,
               issued);
      final_errors++;
    end
    $display("tests %0d, failed %0d, checks failed %0d, credits returned %0d", rsp_count,
             tests_failed, checks_failed + final_errors, credit_pulses);
    if (checks_failed + final_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- design/periph_top.sv
// Peripheral subsystem top: request queue, bus FSM, RAM, GPIO and timer.
`timescale 1ns/1ps

module periph_top import sys_pkg::*; #(
  parameter int unsigned ReqDepth = 2,
  parameter int unsigned RamWords = 256,
  parameter int unsigned GpiWidth = 13,
  parameter int unsigned GpoWidth = 24,
  parameter int unsigned TickDiv  = 4
) (
  input  logic                     clk_sys_i,
  input  logic                     rst_n_i,
  input  logic                     req_valid_i,
  input  bus_op_e                  req_op_i,
  input  logic [BusAddrWidth-1:0]  req_addr_i,
  input  logic [BusDataWidth-1:0]  req_wdata_i,
  input  logic [BusByteEnable-1:0] req_be_i,
  output logic                     credit_o,
  output logic                     rsp_valid_o,
  output logic [BusDataWidth-1:0]  rsp_rdata_o,
  output logic                     rsp_err_o,
  input  logic [GpiWidth-1:0]      gp_i,
  output logic [GpoWidth-1:0]      gp_o,
  output logic                     irq_o
);

  localparam int unsigned RamAddrW = $clog2(RamWords) + 2;

  // Queue head.
  logic                     q_valid;
  bus_op_e                  q_op;
  logic [BusAddrWidth-1:0]  q_addr;
  logic [BusDataWidth-1:0]  q_wdata;
  logic [BusByteEnable-1:0] q_be;
  logic                     q_pop;

  // Shared device bus.
  logic                     ram_req;
  logic                     gpio_req;
  logic                     timer_req;
  logic                     dev_we;
  logic [BusAddrWidth-1:0]  dev_addr;
  logic [BusDataWidth-1:0]  dev_wdata;
  logic [BusByteEnable-1:0] dev_be;
  logic                     ram_rvalid;
  logic [BusDataWidth-1:0]  ram_rdata;
  logic                     gpio_rvalid;
  logic [BusDataWidth-1:0]  gpio_rdata;
  logic                     timer_rvalid;
  logic [BusDataWidth-1:0]  timer_rdata;
  logic                     timer_err;

  req_queue #(
    .ReqDepth(ReqDepth)
  ) u_req_queue (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .push_i   (req_valid_i),
    .op_i     (req_op_i),
    .addr_i   (req_addr_i),
    .wdata_i  (req_wdata_i),
    .be_i     (req_be_i),
    .pop_i    (q_pop),
    .valid_o  (q_valid),
    .op_o     (q_op),
    .addr_o   (q_addr),
    .wdata_o  (q_wdata),
    .be_o     (q_be),
    .credit_o (credit_o)
  );

  bus_fsm #(
    .RamWords(RamWords)
  ) u_bus_fsm (
    .clk_sys_i     (clk_sys_i),
    .rst_n_i       (rst_n_i),
    .q_valid_i     (q_valid),
    .q_op_i        (q_op),
    .q_addr_i      (q_addr),
    .q_wdata_i     (q_wdata),
    .q_be_i        (q_be),
    .q_pop_o       (q_pop),
    .ram_req_o     (ram_req),
    .gpio_req_o    (gpio_req),
    .timer_req_o   (timer_req),
    .dev_we_o      (dev_we),
    .dev_addr_o    (dev_addr),
    .dev_wdata_o   (dev_wdata),
    .dev_be_o      (dev_be),
    .ram_rvalid_i  (ram_rvalid),
    .ram_rdata_i   (ram_rdata),
    .gpio_rvalid_i (gpio_rvalid),
    .gpio_rdata_i  (gpio_rdata),
    .timer_rvalid_i(timer_rvalid),
    .timer_rdata_i (timer_rdata),
    .timer_err_i   (timer_err),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_rdata_o   (rsp_rdata_o),
    .rsp_err_o     (rsp_err_o)
  );

  ////////////////////
  // Devices.
  ////////////////////

  data_ram #(
    .RamWords(RamWords)
  ) u_data_ram (
    .clk_sys_i(clk_sys_i),
    .req_i    (ram_req),
    .we_i     (dev_we),
    .addr_i   (dev_addr[RamAddrW-1:0]),
    .wdata_i  (dev_wdata),
    .be_i     (dev_be),
    .rvalid_o (ram_rvalid),
    .rdata_o  (ram_rdata)
  );

  gpio_regs #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) u_gpio_regs (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .req_i    (gpio_req),
    .we_i     (dev_we),
    .addr_i   (dev_addr[RegAddrWidth-1:0]),
    .wdata_i  (dev_wdata),
    .be_i     (dev_be),
    .rvalid_o (gpio_rvalid),
    .rdata_o  (gpio_rdata),
    .gp_i     (gp_i),
    .gp_o     (gp_o)
  );

  mtimer #(
    .TickDiv(TickDiv)
  ) u_mtimer (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .req_i    (timer_req),
    .we_i     (dev_we),
    .addr_i   (dev_addr[RegAddrWidth-1:0]),
    .wdata_i  (dev_wdata),
    .be_i     (dev_be),
    .rvalid_o (timer_rvalid),
    .rdata_o  (timer_rdata),
    .err_o    (timer_err),
    .irq_o    (irq_o)
  );

endmodule

//--- design/mtimer.sv
// Machine timer: prescaled mtime, mtimecmp, enable control and interrupt.
`timescale 1ns/1ps

module mtimer import sys_pkg::*; #(
  parameter int unsigned TickDiv = 4
) (
  input  logic                     clk_sys_i,
  input  logic                     rst_n_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [RegAddrWidth-1:0]  addr_i,
  input  logic [BusDataWidth-1:0]  wdata_i,
  input  logic [BusByteEnable-1:0] be_i,
  output logic                     rvalid_o,
  output logic [BusDataWidth-1:0]  rdata_o,
  output logic                     err_o,
  output logic                     irq_o
);

  localparam int unsigned PreW = (TickDiv > 1) ? $clog2(TickDiv) : 1;
  localparam logic [PreW-1:0] PreLast = PreW'(TickDiv - 1);

  logic [PreW-1:0]         pre_q;
  logic [BusDataWidth-1:0] mtime_q;
  logic [BusDataWidth-1:0] mtimecmp_q;
  logic                    en_q;
  logic                    tick;
  logic                    known;

  assign tick  = en_q && (pre_q == PreLast);
  assign known = addr_i inside {MtimeOffset, MtimecmpOffset, TimerCtrlOffset};

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      pre_q      <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '0;
      en_q       <= 1'b0;
      irq_o      <= 1'b0;
      rvalid_o   <= 1'b0;
      err_o      <= 1'b0;
    end else begin
      // Prescaler holds at zero while disabled.
      pre_q <= (!en_q || tick) ? '0 : pre_q + 1'b1;
      if (tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      // Bus writes win over the increment.
      if (req_i && we_i) begin
        case (addr_i)
          MtimeOffset:     mtime_q    <= merge_bytes(mtime_q, wdata_i, be_i);
          MtimecmpOffset:  mtimecmp_q <= merge_bytes(mtimecmp_q, wdata_i, be_i);
          TimerCtrlOffset: if (be_i[0]) en_q <= wdata_i[0];
          default: ;
        endcase
      end
      irq_o    <= en_q && (mtime_q >= mtimecmp_q);
      rvalid_o <= req_i;
      err_o    <= req_i && !known;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      case (addr_i)
        MtimeOffset:     rdata_o <= mtime_q;
        MtimecmpOffset:  rdata_o <= mtimecmp_q;
        TimerCtrlOffset: rdata_o <= {{(BusDataWidth-1){1'b0}}, en_q};
        default:         rdata_o <= '0;
      endcase
    end
  end

  // mtime moves only on a tick or a bus write.
  a_mtime_holds_disabled: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    !en_q && !(req_i && we_i) |=> $stable(mtime_q));

endmodule

//--- design/gpio_regs.sv
// GPIO registers: byte-writable output and synchronized input.
`timescale 1ns/1ps

module gpio_regs import sys_pkg::*; #(
  parameter int unsigned GpiWidth = 13,
  parameter int unsigned GpoWidth = 24
) (
  input  logic                     clk_sys_i,
  input  logic                     rst_n_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [RegAddrWidth-1:0]  addr_i,
  input  logic [BusDataWidth-1:0]  wdata_i,
  input  logic [BusByteEnable-1:0] be_i,
  output logic                     rvalid_o,
  output logic [BusDataWidth-1:0]  rdata_o,
  input  logic [GpiWidth-1:0]      gp_i,
  output logic [GpoWidth-1:0]      gp_o
);

  logic [GpiWidth-1:0]     gpi_meta;
  logic [GpiWidth-1:0]     gpi_sync;
  logic [BusDataWidth-1:0] gpo_word;

  assign gpo_word = BusDataWidth'(gp_o);

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      gp_o     <= '0;
      gpi_meta <= '0;
      gpi_sync <= '0;
      rvalid_o <= 1'b0;
    end else begin
      // Two flops on the asynchronous inputs.
      gpi_meta <= gp_i;
      gpi_sync <= gpi_meta;
      rvalid_o <= req_i;
      if (req_i && we_i && addr_i == GpoOffset) begin
        gp_o <= GpoWidth'(merge_bytes(gpo_word, wdata_i, be_i));
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      case (addr_i)
        GpoOffset: rdata_o <= gpo_word;
        GpiOffset: rdata_o <= BusDataWidth'(gpi_sync);
        default:   rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- design/data_ram.sv
// Single-port word RAM with byte-lane writes and registered read.
`timescale 1ns/1ps

module data_ram import sys_pkg::*; #(
  parameter int unsigned RamWords = 256
) (
  input  logic                          clk_sys_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [$clog2(RamWords)+1:0]   addr_i,
  input  logic [BusDataWidth-1:0]       wdata_i,
  input  logic [BusByteEnable-1:0]      be_i,
  output logic                          rvalid_o,
  output logic [BusDataWidth-1:0]       rdata_o
);

  localparam int unsigned IdxW = $clog2(RamWords);

  logic [BusDataWidth-1:0] mem [RamWords];
  logic [IdxW-1:0]         idx;

  // Byte offset to word index.
  assign idx = addr_i[IdxW+1:2];

  always_ff @(posedge clk_sys_i) begin
    rvalid_o <= req_i;
    if (req_i) begin
      if (we_i) begin
        mem[idx] <= merge_bytes(mem[idx], wdata_i, be_i);
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

endmodule

//--- design/bus_fsm.sv
// Bus controller FSM: address decode, device issue and in-order response.
`timescale 1ns/1ps

module bus_fsm import sys_pkg::*; #(
  parameter int unsigned RamWords = 256
) (
  input  logic                     clk_sys_i,
  input  logic                     rst_n_i,
  input  logic                     q_valid_i,
  input  bus_op_e                  q_op_i,
  input  logic [BusAddrWidth-1:0]  q_addr_i,
  input  logic [BusDataWidth-1:0]  q_wdata_i,
  input  logic [BusByteEnable-1:0] q_be_i,
  output logic                     q_pop_o,
  output logic                     ram_req_o,
  output logic                     gpio_req_o,
  output logic                     timer_req_o,
  output logic                     dev_we_o,
  output logic [BusAddrWidth-1:0]  dev_addr_o,
  output logic [BusDataWidth-1:0]  dev_wdata_o,
  output logic [BusByteEnable-1:0] dev_be_o,
  input  logic                     ram_rvalid_i,
  input  logic [BusDataWidth-1:0]  ram_rdata_i,
  input  logic                     gpio_rvalid_i,
  input  logic [BusDataWidth-1:0]  gpio_rdata_i,
  input  logic                     timer_rvalid_i,
  input  logic [BusDataWidth-1:0]  timer_rdata_i,
  input  logic                     timer_err_i,
  output logic                     rsp_valid_o,
  output logic [BusDataWidth-1:0]  rsp_rdata_o,
  output logic                     rsp_err_o
);

  localparam logic [BusAddrWidth-1:0] RamLimit = BusAddrWidth'(RamWords * 4);

  bus_state_e               state_q;
  device_e                  dev_sel;
  device_e                  dev_q;
  bus_op_e                  op_q;
  logic [BusAddrWidth-1:0]  offset;
  logic [BusDataWidth-1:0]  wdata_q;
  logic [BusByteEnable-1:0] be_q;
  logic [BusDataWidth-1:0]  rdata_q;
  logic                     err_q;
  logic                     sel_rvalid;
  logic [BusDataWidth-1:0]  sel_rdata;
  logic                     sel_err;

  ////////////////////
  // Decode.
  ////////////////////

  always_comb begin
    dev_sel = DevNone;
    offset  = q_addr_i & RegionMask;
    if ((q_addr_i - RamBase) < RamLimit) begin
      dev_sel = DevRam;
      offset  = q_addr_i - RamBase;
    end else if ((q_addr_i & ~RegionMask) == GpioBase) begin
      dev_sel = DevGpio;
    end else if ((q_addr_i & ~RegionMask) == TimerBase) begin
      dev_sel = DevTimer;
    end
  end

  // Reply of the device that was issued to.
  always_comb begin
    sel_rvalid = 1'b0;
    sel_rdata  = '0;
    sel_err    = 1'b0;
    case (dev_q)
      DevRam: begin
        sel_rvalid = ram_rvalid_i;
        sel_rdata  = ram_rdata_i;
      end
      DevGpio: begin
        sel_rvalid = gpio_rvalid_i;
        sel_rdata  = gpio_rdata_i;
      end
      DevTimer: begin
        sel_rvalid = timer_rvalid_i;
        sel_rdata  = timer_rdata_i;
        sel_err    = timer_err_i;
      end
      default: ;
    endcase
  end

  assign q_pop_o     = (state_q == StIdle) && q_valid_i;
  assign ram_req_o   = (state_q == StIssue) && (dev_q == DevRam);
  assign gpio_req_o  = (state_q == StIssue) && (dev_q == DevGpio);
  assign timer_req_o = (state_q == StIssue) && (dev_q == DevTimer);
  assign dev_we_o    = (op_q == OpWrite);
  assign dev_wdata_o = wdata_q;
  assign dev_be_o    = be_q;
  assign rsp_valid_o = (state_q == StRespond);
  assign rsp_rdata_o = rdata_q;
  assign rsp_err_o   = err_q;

  ////////////////////
  // State.
  ////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
    end else begin
      case (state_q)
        StIdle:    if (q_valid_i) state_q <= StIssue;
        StIssue:   state_q <= (dev_q == DevNone) ? StRespond : StWait;
        StWait:    if (sel_rvalid) state_q <= StRespond;
        StRespond: state_q <= StIdle;
        default:   state_q <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (q_pop_o) begin
      dev_q      <= dev_sel;
      op_q       <= q_op_i;
      dev_addr_o <= offset;
      wdata_q    <= q_wdata_i;
      be_q       <= q_be_i;
    end
    // Unmapped access answers without touching a device.
    if (state_q == StIssue && dev_q == DevNone) begin
      rdata_q <= '0;
      err_q   <= 1'b1;
    end
    if (state_q == StWait && sel_rvalid) begin
      rdata_q <= sel_rdata;
      err_q   <= sel_err;
    end
  end

  a_one_rvalid: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    $onehot0({ram_rvalid_i, gpio_rvalid_i, timer_rvalid_i}));

endmodule

//--- design/req_queue.sv
// Request FIFO with one credit returned per popped entry.
`timescale 1ns/1ps

module req_queue import sys_pkg::*; #(
  parameter int unsigned ReqDepth = 2
) (
  input  logic                     clk_sys_i,
  input  logic                     rst_n_i,
  input  logic                     push_i,
  input  bus_op_e                  op_i,
  input  logic [BusAddrWidth-1:0]  addr_i,
  input  logic [BusDataWidth-1:0]  wdata_i,
  input  logic [BusByteEnable-1:0] be_i,
  input  logic                     pop_i,
  output logic                     valid_o,
  output bus_op_e                  op_o,
  output logic [BusAddrWidth-1:0]  addr_o,
  output logic [BusDataWidth-1:0]  wdata_o,
  output logic [BusByteEnable-1:0] be_o,
  output logic                     credit_o
);

  localparam int unsigned PtrW = (ReqDepth > 1) ? $clog2(ReqDepth) : 1;
  localparam int unsigned CntW = $clog2(ReqDepth + 1);
  localparam logic [PtrW-1:0] LastPtr = PtrW'(ReqDepth - 1);

  bus_op_e                  op_mem   [ReqDepth];
  logic [BusAddrWidth-1:0]  addr_mem [ReqDepth];
  logic [BusDataWidth-1:0]  wdata_mem[ReqDepth];
  logic [BusByteEnable-1:0] be_mem   [ReqDepth];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_pop;
  logic            full;

  assign valid_o  = (count_q != '0);
  assign full     = (count_q == CntW'(ReqDepth));
  assign do_pop   = pop_i && valid_o;
  // Each freed entry goes straight back to the host.
  assign credit_o = do_pop;

  assign op_o    = op_mem[rd_ptr_q];
  assign addr_o  = addr_mem[rd_ptr_q];
  assign wdata_o = wdata_mem[rd_ptr_q];
  assign be_o    = be_mem[rd_ptr_q];

  always_ff @(posedge clk_sys_i) begin
    if (push_i) begin
      op_mem[wr_ptr_q]    <= op_i;
      addr_mem[wr_ptr_q]  <= addr_i;
      wdata_mem[wr_ptr_q] <= wdata_i;
      be_mem[wr_ptr_q]    <= be_i;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(push_i) - CntW'(do_pop);
    end
  end

  // The host never pushes without a credit.
  a_no_overflow: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    push_i |-> !full);

endmodule

//--- design/sys_pkg.sv
// Bus widths, address map, register offsets, byte-merge helper and shared enums.
package sys_pkg;

  localparam int unsigned BusAddrWidth  = 32;
  localparam int unsigned BusDataWidth  = 32;
  localparam int unsigned BusByteEnable = 4;
  localparam int unsigned RegAddrWidth  = 8;

  ////////////////////
  // Address map.
  ////////////////////

  localparam logic [BusAddrWidth-1:0] RamBase    = 32'h0000_0000;
  localparam logic [BusAddrWidth-1:0] GpioBase   = 32'h8000_0000;
  localparam logic [BusAddrWidth-1:0] TimerBase  = 32'h8000_1000;
  localparam logic [BusAddrWidth-1:0] RegionMask = 32'h0000_0FFF;

  localparam logic [RegAddrWidth-1:0] GpoOffset       = 8'h00;
  localparam logic [RegAddrWidth-1:0] GpiOffset       = 8'h04;
  localparam logic [RegAddrWidth-1:0] MtimeOffset     = 8'h00;
  localparam logic [RegAddrWidth-1:0] MtimecmpOffset  = 8'h04;
  localparam logic [RegAddrWidth-1:0] TimerCtrlOffset = 8'h08;

  typedef enum logic {OpRead, OpWrite} bus_op_e;
  typedef enum logic [1:0] {DevRam, DevGpio, DevTimer, DevNone} device_e;
  typedef enum logic [1:0] {StIdle, StIssue, StWait, StRespond} bus_state_e;

  // Replace the enabled byte lanes of a word.
  function automatic logic [BusDataWidth-1:0] merge_bytes(
    input logic [BusDataWidth-1:0]  old_word,
    input logic [BusDataWidth-1:0]  new_word,
    input logic [BusByteEnable-1:0] be
  );
    logic [BusDataWidth-1:0] res;
    res = old_word;
    for (int i = 0; i < BusByteEnable; i++) begin
      if (be[i]) begin
        res[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return res;
  endfunction

endpackage
